// File: bench/ir_receiver_sva.sv
`timescale 1ns/1ps

module ir_receiver_sva (
    input logic            clk,
    input logic            rst_n,
    input logic            key_req,
    input logic            key_ack,
    input ir_pkg::ir_key_t key_code,
    input logic            key_repeat
);

    // request stays up until the consumer answers
    req_held_until_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        key_req && !key_ack |=> key_req
    ) else $error("key_req dropped before key_ack was seen");

    // held event must not move under an open request
    data_stable_under_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        key_req && $past(key_req) |-> $stable(key_code) && $stable(key_repeat)
    ) else $error("key_code or key_repeat changed while key_req high");

    req_rise_needs_ack_low: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(key_req) |-> !key_ack && !$past(key_ack)
    ) else $error("key_req rose while key_ack high");

endmodule

bind ir_receiver_top ir_receiver_sva i_ir_receiver_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .key_req    (key_req),
    .key_ack    (key_ack),
    .key_code   (key_code),
    .key_repeat (key_repeat)
);

// File: bench/tb_ir_receiver.sv
`timescale 1ns/1ps

module tb_ir_receiver;
    import ir_pkg::*;

    localparam int TB_CLK_PER_TICK = 4;      // short tick for simulation
    localparam int GAP_TICKS       = 24;     // idle line after each frame
    localparam int EVENT_TIMEOUT   = 400;    // cycles
    localparam int HOLD_TIMEOUT    = 60000;  // cycles an ack may be withheld
    localparam int NUM_STEPS       = 14;

    typedef enum logic [1:0] {
        FRM_NORMAL,
        FRM_REPEAT,
        FRM_BAD_SPACE,   // one bit space between the zero and one windows
        FRM_SHORT_LEAD   // leader mark far below 9 ms
    } frame_kind_t;

    typedef struct packed {
        frame_kind_t kind;
        ir_addr_t    addr;
        ir_key_t     key;
        ir_key_t     inv;
        logic        hold_ack;
        logic        exp_event;
        ir_key_t     exp_key;
        logic        exp_rpt;
        drop_cnt_t   exp_drop;
    } step_t;

    logic       clk;
    logic       rst_n;
    logic       ir_rxd;
    logic       key_ack;
    logic       key_req;
    ir_key_t    key_code;
    logic       key_repeat;
    drop_cnt_t  drop_count;

    step_t      steps [NUM_STEPS];
    logic       hold_ack;
    ir_key_t    seen_key [$];  // one entry per rising key_req
    logic       seen_rpt [$];
    logic       req_q;
    logic       ack_q;
    logic [8:0] held_q;        // key_code and key_repeat of last cycle
    int         err_cnt;
    int         timeout_cnt;

    ir_receiver_top #(
        .CLK_PER_TICK (TB_CLK_PER_TICK)
    ) i_ir_receiver_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .ir_rxd     (ir_rxd),
        .key_req    (key_req),
        .key_ack    (key_ack),
        .key_code   (key_code),
        .key_repeat (key_repeat),
        .drop_count (drop_count)
    );

    always #5 clk = ~clk;

    task automatic report_error(input string msg);
        err_cnt++;
        $display("ERR @%0t: %s", $time, msg);
    endtask

    task automatic report_timeout(input string msg);
        timeout_cnt++;
        $display("timeout at %0t: %s", $time, msg);
    endtask

    // one line level for a number of ticks plus 0 or 1 tick of jitter
    task automatic drive_line(input logic level, input int ticks);
        int cycles;
        cycles = (ticks + int'($urandom_range(1, 0))) * TB_CLK_PER_TICK;
        ir_rxd <= level;
        repeat (cycles) @(posedge clk);
    endtask

    task automatic send_frame(input step_t st);
        ir_frame_t bits;
        int        i;
        bits = {st.addr, st.key, st.inv};
        drive_line(1'b0, (st.kind == FRM_SHORT_LEAD) ? 90 : 128);  // leader mark
        if (st.kind == FRM_REPEAT) begin
            drive_line(1'b1, 32);
        end else begin
            drive_line(1'b1, 64);
            for (i = 31; i >= 0; i--) begin
                drive_line(1'b0, 8);
                if (st.kind == FRM_BAD_SPACE && i == 20) begin
                    drive_line(1'b1, 16);  // fits neither bit value
                end else begin
                    drive_line(1'b1, bits[i] ? 24 : 8);
                end
            end
        end
        drive_line(1'b0, 8);  // stop mark closes the last space
        drive_line(1'b1, GAP_TICKS);
    endtask

    // ========================================================================
    // consumer side of the handshake
    // ========================================================================
    always begin : ack_responder
        int wait_cnt;
        @(posedge clk);
        if (rst_n && key_req && !key_ack) begin
            wait_cnt = 0;
            while (hold_ack && wait_cnt < HOLD_TIMEOUT) begin
                @(posedge clk);
                wait_cnt++;
            end
            if (hold_ack) report_timeout("ack was withheld longer than expected");
            repeat ($urandom_range(5, 1)) @(posedge clk);
            key_ack <= 1'b1;
            wait_cnt = 0;
            do begin
                @(posedge clk);
                wait_cnt++;
            end while (key_req && wait_cnt < EVENT_TIMEOUT);
            if (key_req) report_timeout("key_req stayed high after key_ack");
            key_ack <= 1'b0;
        end
    end

    // records each request and watches the handshake rules
    always @(posedge clk) begin : req_monitor
        if (!rst_n) begin
            req_q  <= 1'b0;
            ack_q  <= 1'b0;
            held_q <= '0;
        end else begin
            if (key_req && !req_q) begin
                assert (!key_ack && !ack_q) else report_error("key_req rose with key_ack high");
                seen_key.push_back(key_code);
                seen_rpt.push_back(key_repeat);
            end
            if (key_req && req_q) begin
                assert ({key_code, key_repeat} == held_q)
                    else report_error("key data changed under key_req");
            end
            if (req_q && !key_req) begin
                assert (ack_q) else report_error("key_req dropped without key_ack");
            end
            req_q  <= key_req;
            ack_q  <= key_ack;
            held_q <= {key_code, key_repeat};
        end
    end

    // ========================================================================
    // stimulus table and checks
    // ========================================================================
    initial begin : main_sequence
        int    idx;
        int    wait_cnt;
        step_t st;
        clk         = 1'b0;
        rst_n       = 1'b0;
        ir_rxd      = 1'b1;  // idle line
        key_ack     = 1'b0;
        hold_ack    = 1'b0;
        err_cnt     = 0;
        timeout_cnt = 0;
        void'($urandom(7471));

        // kind, addr, key, inv, hold, event, key, rpt, drops
        steps[0]  = '{FRM_REPEAT,     16'h00B6, 8'h00, 8'h00, 1'b0, 1'b0, 8'h00, 1'b0, 8'd0};
        steps[1]  = '{FRM_NORMAL,     16'h00B6, 8'h12, 8'hED, 1'b0, 1'b1, 8'h12, 1'b0, 8'd0};
        steps[2]  = '{FRM_NORMAL,     16'h00B6, 8'h5A, 8'hA5, 1'b0, 1'b1, 8'h5A, 1'b0, 8'd0};
        steps[3]  = '{FRM_REPEAT,     16'h00B6, 8'h00, 8'h00, 1'b0, 1'b1, 8'h5A, 1'b1, 8'd0};
        steps[4]  = '{FRM_NORMAL,     16'h00B7, 8'h33, 8'hCC, 1'b0, 1'b0, 8'h00, 1'b0, 8'd0};
        steps[5]  = '{FRM_NORMAL,     16'h00B6, 8'h44, 8'h44, 1'b0, 1'b0, 8'h00, 1'b0, 8'd0};
        steps[6]  = '{FRM_BAD_SPACE,  16'h00B6, 8'h21, 8'hDE, 1'b0, 1'b0, 8'h00, 1'b0, 8'd0};
        steps[7]  = '{FRM_NORMAL,     16'h00B6, 8'h21, 8'hDE, 1'b0, 1'b1, 8'h21, 1'b0, 8'd0};
        steps[8]  = '{FRM_SHORT_LEAD, 16'h00B6, 8'h7E, 8'h81, 1'b0, 1'b0, 8'h00, 1'b0, 8'd0};
        steps[9]  = '{FRM_NORMAL,     16'h00B6, 8'h7E, 8'h81, 1'b0, 1'b1, 8'h7E, 1'b0, 8'd0};
        steps[10] = '{FRM_NORMAL,     16'h00B6, 8'h0F, 8'hF0, 1'b1, 1'b1, 8'h0F, 1'b0, 8'd0};
        steps[11] = '{FRM_NORMAL,     16'h00B6, 8'h99, 8'h66, 1'b1, 1'b0, 8'h0F, 1'b0, 8'd1};
        steps[12] = '{FRM_NORMAL,     16'h00B6, 8'hC3, 8'h3C, 1'b0, 1'b1, 8'hC3, 1'b0, 8'd1};
        steps[13] = '{FRM_REPEAT,     16'h00B6, 8'h00, 8'h00, 1'b0, 1'b1, 8'hC3, 1'b1, 8'd1};

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);

        // outputs right after reset
        assert (!key_req && key_code == 8'h00 && !key_repeat && drop_count == 8'd0)
            else report_error($sformatf("after reset: req %0b key %02h rpt %0b drops %0d",
                                        key_req, key_code, key_repeat, drop_count));

        for (idx = 0; idx < NUM_STEPS; idx++) begin
            st = steps[idx];
            hold_ack <= st.hold_ack;
            send_frame(st);

            wait_cnt = 0;
            while (st.exp_event && seen_key.size() == 0 && wait_cnt < EVENT_TIMEOUT) begin
                @(posedge clk);
                wait_cnt++;
            end
            if (st.exp_event && seen_key.size() == 0) begin
                report_timeout($sformatf("no key_req for step %0d", idx));
            end
            wait_cnt = 0;
            while (!st.hold_ack && (key_req || key_ack) && wait_cnt < EVENT_TIMEOUT) begin
                @(posedge clk);
                wait_cnt++;
            end
            if (!st.hold_ack && (key_req || key_ack)) begin
                report_timeout($sformatf("handshake of step %0d did not finish", idx));
            end

            if (st.exp_event) begin
                assert (seen_key.size() == 1)
                    else report_error($sformatf("step %0d: %0d requests, expected 1",
                                                idx, seen_key.size()));
                if (seen_key.size() > 0) begin
                    assert (seen_key[0] == st.exp_key && seen_rpt[0] == st.exp_rpt)
                        else report_error($sformatf("step %0d: key %02h rpt %0b, expected %02h %0b",
                                                    idx, seen_key[0], seen_rpt[0],
                                                    st.exp_key, st.exp_rpt));
                end
            end else begin
                assert (seen_key.size() == 0)
                    else report_error($sformatf("step %0d: unexpected key_req", idx));
            end
            seen_key.delete();
            seen_rpt.delete();

            assert (drop_count == st.exp_drop)
                else report_error($sformatf("step %0d: drop_count %0d, expected %0d",
                                            idx, drop_count, st.exp_drop));
            if (st.hold_ack) begin
                assert (key_req && key_code == st.exp_key)
                    else report_error($sformatf("step %0d: held key %02h, expected %02h",
                                                idx, key_code, st.exp_key));
            end
        end

        repeat (10) @(posedge clk);
        $display("errors: %0d wrong values, %0d timeouts", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: flist.f
verilog/ir_pkg.sv
verilog/ir_pulse_if.sv
verilog/ir_key_if.sv
verilog/ir_pulse_timer.sv
verilog/ir_frame_decoder.sv
verilog/ir_key_port.sv
verilog/ir_receiver_top.sv
bench/ir_receiver_sva.sv
bench/tb_ir_receiver.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the IR receiver testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_ir_receiver -Mdir "$BUILD_DIR" -f flist.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_ir_receiver" +verilator+error+limit+100 > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qF '*** TEST PASSED ***' "$LOG_FILE"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi

// File: verilog/ir_frame_decoder.sv
`timescale 1ns/1ps

module ir_frame_decoder (
    input  logic   clk,
    input  logic   rst_n,
    ir_pulse_if.rx pulse,
    ir_key_if.tx   key_ev
);
    import ir_pkg::*;

    dec_state_t state_q;
    dec_state_t state_d;
    bit_idx_t   bit_idx_q;
    logic       rpt_q;       // current delivery is a repeat
    logic       have_key_q;  // a valid frame was seen since reset
    ir_frame_t  frame_q;
    ir_key_t    last_key_q;

    logic       mark_strobe;
    logic       space_strobe;
    logic       lead_mark_ok;
    logic       lead_space_ok;
    logic       rpt_space_ok;
    logic       bit_mark_ok;
    logic       zero_ok;
    logic       one_ok;
    logic       bit_accept;
    ir_addr_t   frame_addr;
    ir_key_t    frame_key;
    ir_key_t    frame_inv;
    logic       frame_ok;

    function automatic logic in_window(tick_cnt_t len, tick_cnt_t lo, tick_cnt_t hi);
        return (len >= lo) && (len <= hi);
    endfunction

    // ========================================================================
    // pulse classification
    // ========================================================================
    assign mark_strobe  = pulse.valid && pulse.level;
    assign space_strobe = pulse.valid && !pulse.level;

    // a saturated length never fits any window
    assign lead_mark_ok  = !pulse.ovf && in_window(pulse.ticks, LEAD_MARK_MIN, LEAD_MARK_MAX);
    assign lead_space_ok = !pulse.ovf && in_window(pulse.ticks, LEAD_SPACE_MIN, LEAD_SPACE_MAX);
    assign rpt_space_ok  = !pulse.ovf && in_window(pulse.ticks, RPT_SPACE_MIN, RPT_SPACE_MAX);
    assign bit_mark_ok   = !pulse.ovf && in_window(pulse.ticks, BIT_MARK_MIN, BIT_MARK_MAX);
    assign zero_ok       = !pulse.ovf && in_window(pulse.ticks, ZERO_SPACE_MIN, ZERO_SPACE_MAX);
    assign one_ok        = !pulse.ovf && in_window(pulse.ticks, ONE_SPACE_MIN, ONE_SPACE_MAX);

    assign bit_accept = (state_q == DEC_BIT_SPACE) && space_strobe && (zero_ok || one_ok);

    // ========================================================================
    // protocol state machine, advances on strobes only
    // ========================================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            DEC_IDLE: begin
                if (space_strobe) begin
                    state_d = DEC_LEAD_MARK;  // line went low, mark has begun
                end else if (mark_strobe && lead_mark_ok) begin
                    state_d = DEC_LEAD_SPACE;
                end
            end
            DEC_LEAD_MARK: begin
                if (pulse.valid) begin
                    state_d = (mark_strobe && lead_mark_ok) ? DEC_LEAD_SPACE : DEC_IDLE;
                end
            end
            DEC_LEAD_SPACE: begin
                if (space_strobe && lead_space_ok) begin
                    state_d = DEC_BIT_MARK;
                end else if (space_strobe && rpt_space_ok && have_key_q) begin
                    state_d = DEC_DELIVER;
                end else if (pulse.valid) begin
                    state_d = DEC_IDLE;
                end
            end
            DEC_BIT_MARK: begin
                if (pulse.valid) begin
                    state_d = (mark_strobe && bit_mark_ok) ? DEC_BIT_SPACE : DEC_IDLE;
                end
            end
            DEC_BIT_SPACE: begin
                if (bit_accept) begin
                    state_d = (bit_idx_q == LAST_BIT) ? DEC_DELIVER : DEC_BIT_MARK;
                end else if (pulse.valid) begin
                    state_d = DEC_IDLE;  // space fits neither bit value
                end
            end
            DEC_DELIVER: state_d = DEC_IDLE;
            default:     state_d = DEC_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= DEC_IDLE;
            bit_idx_q  <= '0;
            rpt_q      <= 1'b0;
            have_key_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == DEC_LEAD_SPACE) begin
                bit_idx_q <= '0;
            end else if (bit_accept) begin
                bit_idx_q <= bit_idx_q + 1'b1;
            end
            if (state_d == DEC_DELIVER) begin
                rpt_q <= (state_q == DEC_LEAD_SPACE);
            end
            if (state_q == DEC_DELIVER && !rpt_q && frame_ok) begin
                have_key_q <= 1'b1;
            end
        end
    end

    // bit assembly, msb first, and the key kept for repeats
    always_ff @(posedge clk) begin
        if (bit_accept) begin
            frame_q <= {frame_q[FRAME_BITS-2:0], one_ok};
        end
        if (state_q == DEC_DELIVER && !rpt_q && frame_ok) begin
            last_key_q <= frame_key;
        end
    end

    // ========================================================================
    // frame check and event output
    // ========================================================================
    assign frame_addr = frame_q[31:16];
    assign frame_key  = frame_q[15:8];
    assign frame_inv  = frame_q[7:0];
    assign frame_ok   = (frame_addr == IR_CUSTOM_CODE) && (frame_inv == ~frame_key);

    assign key_ev.valid = (state_q == DEC_DELIVER) && (rpt_q || frame_ok);
    assign key_ev.key   = rpt_q ? last_key_q : frame_key;
    assign key_ev.rpt   = rpt_q;
    assign key_ev.addr  = rpt_q ? IR_CUSTOM_CODE : frame_addr;

endmodule

// File: verilog/ir_key_if.sv
`timescale 1ns/1ps

// decoded key event, decoder to output port
interface ir_key_if;
    import ir_pkg::*;

    logic     valid;  // single-cycle strobe per accepted event
    ir_key_t  key;
    logic     rpt;    // repeat frame, key is the last one delivered
    ir_addr_t addr;   // custom code the event belongs to

    modport tx (
        output valid,
        output key,
        output rpt,
        output addr
    );

    modport rx (
        input valid,
        input key,
        input rpt,
        input addr
    );

endinterface

// File: verilog/ir_key_port.sv
`timescale 1ns/1ps

module ir_key_port (
    input  logic              clk,
    input  logic              rst_n,
    ir_key_if.rx              key_ev,
    output logic              key_req,
    input  logic              key_ack,
    output ir_pkg::ir_key_t   key_code,
    output logic              key_repeat,
    output ir_pkg::drop_cnt_t drop_count
);
    import ir_pkg::*;

    port_state_t state_q;
    logic        accept;
    logic        drop;

    // new request only when not requesting and the consumer has let go
    assign accept = key_ev.valid && (state_q != PORT_REQ) && !key_ack;
    assign drop   = key_ev.valid && !accept;

    assign key_req = (state_q == PORT_REQ);

    // ========================================================================
    // four-phase sequence
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= PORT_IDLE;
        end else begin
            case (state_q)
                PORT_IDLE:    if (accept) state_q <= PORT_REQ;
                PORT_REQ:     if (key_ack) state_q <= PORT_RELEASE;
                PORT_RELEASE: begin
                    if (accept) begin
                        state_q <= PORT_REQ;  // ack already low, go straight on
                    end else if (!key_ack) begin
                        state_q <= PORT_IDLE;
                    end
                end
                default:      state_q <= PORT_IDLE;
            endcase
        end
    end

    // held event and dropped-event count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_code   <= '0;
            key_repeat <= 1'b0;
            drop_count <= '0;
        end else begin
            if (accept) begin
                key_code   <= key_ev.key;
                key_repeat <= key_ev.rpt;
            end
            if (drop && drop_count != DROP_MAX) begin
                drop_count <= drop_count + 1'b1;  // saturating
            end
        end
    end

endmodule

// File: verilog/ir_pkg.sv
package ir_pkg;

    // ========================================================================
    // widths and data types
    // ========================================================================
    localparam int TICK_W     = 8;   // pulse length counter
    localparam int PRESCALE_W = 16;  // clock divider, enough for 3516 at 50 MHz
    localparam int FRAME_BITS = 32;
    localparam int DROP_W     = 8;

    typedef logic [TICK_W-1:0]     tick_cnt_t;  // one tick = 562.5 us / 8
    typedef logic [PRESCALE_W-1:0] prescale_t;
    typedef logic [FRAME_BITS-1:0] ir_frame_t;  // raw bits, first received in msb
    typedef logic [15:0]           ir_addr_t;
    typedef logic [7:0]            ir_key_t;
    typedef logic [DROP_W-1:0]     drop_cnt_t;
    typedef logic [4:0]            bit_idx_t;   // 0..31 within a frame

    localparam tick_cnt_t TICK_MAX = '1;          // saturation value
    localparam drop_cnt_t DROP_MAX = '1;
    localparam bit_idx_t  LAST_BIT = bit_idx_t'(FRAME_BITS - 1);

    // accepted custom code of the remote
    localparam ir_addr_t IR_CUSTOM_CODE = 16'h00B6;

    // ========================================================================
    // protocol windows in ticks, inclusive
    // ========================================================================
    localparam tick_cnt_t LEAD_MARK_MIN  = 8'd120;  // 9 ms nominal 128
    localparam tick_cnt_t LEAD_MARK_MAX  = 8'd136;
    localparam tick_cnt_t LEAD_SPACE_MIN = 8'd58;   // 4.5 ms nominal 64
    localparam tick_cnt_t LEAD_SPACE_MAX = 8'd70;
    localparam tick_cnt_t RPT_SPACE_MIN  = 8'd28;   // 2.25 ms nominal 32
    localparam tick_cnt_t RPT_SPACE_MAX  = 8'd36;
    localparam tick_cnt_t BIT_MARK_MIN   = 8'd6;    // 562.5 us nominal 8
    localparam tick_cnt_t BIT_MARK_MAX   = 8'd10;
    localparam tick_cnt_t ZERO_SPACE_MIN = 8'd6;
    localparam tick_cnt_t ZERO_SPACE_MAX = 8'd10;
    localparam tick_cnt_t ONE_SPACE_MIN  = 8'd20;   // 1.6875 ms nominal 24
    localparam tick_cnt_t ONE_SPACE_MAX  = 8'd28;

    // ========================================================================
    // state machines
    // ========================================================================
    typedef enum logic [2:0] {
        DEC_IDLE,        // waiting for a mark to begin
        DEC_LEAD_MARK,   // leader mark in progress
        DEC_LEAD_SPACE,  // leader space, full or repeat
        DEC_BIT_MARK,
        DEC_BIT_SPACE,
        DEC_DELIVER      // one cycle, frame checked and handed on
    } dec_state_t;

    typedef enum logic [1:0] {
        PORT_IDLE,
        PORT_REQ,        // key_req high, data held
        PORT_RELEASE     // waiting for key_ack to drop
    } port_state_t;

endpackage

// File: verilog/ir_pulse_if.sv
`timescale 1ns/1ps

// one measured pulse, timer to decoder, no back-pressure
interface ir_pulse_if;
    import ir_pkg::*;

    logic      valid;  // single-cycle strobe at each line edge
    logic      level;  // 1 for a mark, line was low
    tick_cnt_t ticks;  // length of the finished pulse
    logic      ovf;    // length hit the counter ceiling

    modport tx (
        output valid,
        output level,
        output ticks,
        output ovf
    );

    modport rx (
        input valid,
        input level,
        input ticks,
        input ovf
    );

endinterface

// File: verilog/ir_pulse_timer.sv
`timescale 1ns/1ps

module ir_pulse_timer #(
    parameter int unsigned CLK_PER_TICK = 3516  // 50 MHz clock, 70.3 us tick
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   ir_rxd,  // detector output, low while carrier present
    ir_pulse_if.tx pulse
);
    import ir_pkg::*;

    logic      rxd_meta;
    logic      rxd_sync;
    logic      rxd_prev;    // edge register
    logic      line_edge;
    prescale_t prescale_q;
    logic      tick_en;
    tick_cnt_t tick_q;
    logic      tick_sat;

    // ========================================================================
    // input synchronizer, idle level is high
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= ir_rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign line_edge = rxd_sync ^ rxd_prev;

    // ========================================================================
    // free-running tick prescaler
    // ========================================================================
    assign tick_en = (prescale_q == prescale_t'(CLK_PER_TICK - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prescale_q <= '0;
        end else if (tick_en) begin
            prescale_q <= '0;
        end else begin
            prescale_q <= prescale_q + 1'b1;
        end
    end

    // pulse length, restarts on every edge and sticks at the ceiling
    assign tick_sat = (tick_q == TICK_MAX);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_q <= '0;
        end else if (line_edge) begin
            tick_q <= '0;
        end else if (tick_en && !tick_sat) begin
            tick_q <= tick_q + 1'b1;
        end
    end

    // ========================================================================
    // pulse report
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pulse.valid <= 1'b0;
        end else begin
            pulse.valid <= line_edge;
        end
    end

    always_ff @(posedge clk) begin
        if (line_edge) begin
            pulse.level <= ~rxd_prev;  // old level low means a mark just ended
            pulse.ticks <= tick_q;
            pulse.ovf   <= tick_sat;
        end
    end

endmodule

// File: verilog/ir_receiver_top.sv
`timescale 1ns/1ps

module ir_receiver_top #(
    parameter int unsigned CLK_PER_TICK = 3516  // clocks per 70.3 us tick
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ir_rxd,      // raw detector output, active low
    output logic              key_req,
    input  logic              key_ack,
    output ir_pkg::ir_key_t   key_code,
    output logic              key_repeat,
    output ir_pkg::drop_cnt_t drop_count
);

    ir_pulse_if pulse_bus ();
    ir_key_if   key_bus ();

    // ========================================================================
    // line timing, frame decoding, handshake
    // ========================================================================
    ir_pulse_timer #(
        .CLK_PER_TICK (CLK_PER_TICK)
    ) i_ir_pulse_timer (
        .clk    (clk),
        .rst_n  (rst_n),
        .ir_rxd (ir_rxd),
        .pulse  (pulse_bus)
    );

    ir_frame_decoder i_ir_frame_decoder (
        .clk    (clk),
        .rst_n  (rst_n),
        .pulse  (pulse_bus),
        .key_ev (key_bus)
    );

    ir_key_port i_ir_key_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .key_ev     (key_bus),
        .key_req    (key_req),
        .key_ack    (key_ack),
        .key_code   (key_code),
        .key_repeat (key_repeat),
        .drop_count (drop_count)
    );

endmodule
